// ==== Makefile ====
# Verilator build, run and lint for the NI meta buffer
TOP := tb_ni_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then exit 1; fi

lint:
	verilator --lint-only --timing -Wall -Wno-fatal -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/ni_cfg_pkg.sv ====
/*
 * NI meta buffer configuration
 * Channel widths, buffer depths and the atomic operation encoding
 */
package ni_cfg_pkg;

  // Channel field widths
  localparam int unsigned InIdWidth = 4;
  localparam int unsigned OutIdWidth = 3;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SrcWidth = 4;
  localparam int unsigned MetaWidth = SrcWidth + InIdWidth;

  // Ordinary requests share one outgoing ID and queue in order
  localparam int unsigned MaxTxns = 4;
  localparam int unsigned FifoPtrWidth = $clog2(MaxTxns);
  localparam int unsigned NoAtopOutId = 2**OutIdWidth - 1;

  // Atomics own outgoing IDs 0 .. MaxAtomicTxns-1
  localparam int unsigned MaxAtomicTxns = 2;
  localparam int unsigned SlotIdxWidth = $clog2(MaxAtomicTxns);
  localparam int unsigned AtopWidth = 6;
  localparam int unsigned AtopRRespBit = 5;
  localparam logic [1:0] AtopNone = 2'b00;

endpackage

// ==== common/ni_types_pkg.sv ====
/*
 * NI meta buffer types
 * Vector types for channel fields and the stored meta record
 */
package ni_types_pkg;

  typedef logic [ni_cfg_pkg::InIdWidth-1:0] id_in_t;
  typedef logic [ni_cfg_pkg::OutIdWidth-1:0] id_out_t;
  typedef logic [ni_cfg_pkg::AddrWidth-1:0] addr_t;
  typedef logic [ni_cfg_pkg::DataWidth-1:0] data_t;
  typedef logic [ni_cfg_pkg::SrcWidth-1:0] src_t;
  typedef logic [ni_cfg_pkg::AtopWidth-1:0] atop_t;
  typedef logic [ni_cfg_pkg::SlotIdxWidth-1:0] slot_idx_t;

  // Source node in the upper bits, original local ID in the lower bits
  typedef logic [ni_cfg_pkg::MetaWidth-1:0] meta_t;

endpackage

// ==== compile.f ====
common/ni_cfg_pkg.sv
common/ni_types_pkg.sv
meta_buffer/meta_fifo.sv
meta_buffer/atop_slots.sv
meta_buffer/meta_buffer.sv
verilog/ni_top.sv
test/tb_clock.sv
test/tb_ni_top.sv

// ==== meta_buffer/atop_slots.sv ====
/*
 * Atomic slots
 * Per-slot B and R meta registers for outstanding atomics,
 * with the lowest-free-slot pick used as outgoing ID
 */
`timescale 1ns/10ps

module atop_slots (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    alloc_i,
  input  logic                    alloc_r_i,
  input  ni_types_pkg::meta_t     aw_meta_i,
  input  ni_types_pkg::meta_t     ar_meta_i,
  input  logic                    hold_i,
  output ni_types_pkg::slot_idx_t slot_o,
  output logic                    none_free_o,
  input  logic                    b_free_i,
  input  ni_types_pkg::slot_idx_t b_slot_i,
  input  logic                    r_free_i,
  input  ni_types_pkg::slot_idx_t r_slot_i,
  output ni_types_pkg::meta_t     b_meta_o,
  output ni_types_pkg::meta_t     r_meta_o
);

  import ni_cfg_pkg::*;
  import ni_types_pkg::*;

  logic [MaxAtomicTxns-1:0] b_busy_q;
  logic [MaxAtomicTxns-1:0] r_busy_q;
  logic [MaxAtomicTxns-1:0] slot_free;
  meta_t                    b_meta_q [MaxAtomicTxns];
  meta_t                    r_meta_q [MaxAtomicTxns];
  slot_idx_t                pick;
  slot_idx_t                pick_q;
  logic                     hold_q;

  // A slot is reusable only once both its B and R records are gone
  assign slot_free   = ~(b_busy_q | r_busy_q);
  assign none_free_o = (slot_free == '0);

  always_comb begin
    pick = '0;
    for (int i = MaxAtomicTxns - 1; i >= 0; i--) begin
      if (slot_free[i]) begin
        pick = slot_idx_t'(i);
      end
    end
  end

  // Keep the ID stable while the AW waits on the network
  assign slot_o = hold_q ? pick_q : pick;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_q   <= 1'b0;
      pick_q   <= '0;
      b_busy_q <= '0;
      r_busy_q <= '0;
    end else begin
      hold_q <= hold_i;
      if (!hold_q) begin
        pick_q <= pick;
      end
      if (b_free_i) begin
        b_busy_q[b_slot_i] <= 1'b0;
      end
      if (r_free_i) begin
        r_busy_q[r_slot_i] <= 1'b0;
      end
      if (alloc_i) begin
        b_busy_q[slot_o] <= 1'b1;
      end
      if (alloc_r_i) begin
        r_busy_q[slot_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      b_meta_q[slot_o] <= aw_meta_i;
    end
    if (alloc_r_i) begin
      r_meta_q[slot_o] <= ar_meta_i;
    end
  end

  assign b_meta_o = b_meta_q[b_slot_i];
  assign r_meta_o = r_meta_q[r_slot_i];

  a_b_free_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_free_i |-> b_busy_q[b_slot_i]);
  a_r_free_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_free_i |-> r_busy_q[r_slot_i]);
  a_alloc_has_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc_i |-> !none_free_o);

endmodule

// ==== meta_buffer/meta_buffer.sv ====
/*
 * Meta buffer
 * Remaps request IDs, stores a meta record per request and
 * returns it with the original ID on the matching response
 */
`timescale 1ns/10ps

module meta_buffer (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  l_ar_valid_i,
  output logic                  l_ar_ready_o,
  input  ni_types_pkg::id_in_t  l_ar_id_i,
  input  ni_types_pkg::addr_t   l_ar_addr_i,
  input  logic                  l_aw_valid_i,
  output logic                  l_aw_ready_o,
  input  ni_types_pkg::id_in_t  l_aw_id_i,
  input  ni_types_pkg::addr_t   l_aw_addr_i,
  input  ni_types_pkg::atop_t   l_aw_atop_i,
  output logic                  l_r_valid_o,
  input  logic                  l_r_ready_i,
  output ni_types_pkg::id_in_t  l_r_id_o,
  output ni_types_pkg::data_t   l_r_data_o,
  output logic                  l_r_last_o,
  output logic                  l_b_valid_o,
  input  logic                  l_b_ready_i,
  output ni_types_pkg::id_in_t  l_b_id_o,
  output logic                  n_ar_valid_o,
  input  logic                  n_ar_ready_i,
  output ni_types_pkg::id_out_t n_ar_id_o,
  output ni_types_pkg::addr_t   n_ar_addr_o,
  output logic                  n_aw_valid_o,
  input  logic                  n_aw_ready_i,
  output ni_types_pkg::id_out_t n_aw_id_o,
  output ni_types_pkg::addr_t   n_aw_addr_o,
  output ni_types_pkg::atop_t   n_aw_atop_o,
  input  logic                  n_r_valid_i,
  output logic                  n_r_ready_o,
  input  ni_types_pkg::id_out_t n_r_id_i,
  input  ni_types_pkg::data_t   n_r_data_i,
  input  logic                  n_r_last_i,
  input  logic                  n_b_valid_i,
  output logic                  n_b_ready_o,
  input  ni_types_pkg::id_out_t n_b_id_i,
  input  ni_types_pkg::meta_t   ar_meta_i,
  input  ni_types_pkg::meta_t   aw_meta_i,
  output ni_types_pkg::meta_t   r_meta_o,
  output ni_types_pkg::meta_t   b_meta_o
);

  import ni_cfg_pkg::*;
  import ni_types_pkg::*;

  logic      is_atop_aw;
  logic      atop_has_r;
  logic      is_atop_r;
  logic      is_atop_b;
  logic      ar_full;
  logic      ar_empty;
  logic      aw_full;
  logic      aw_empty;
  logic      aw_blocked;
  logic      aw_hs;
  logic      l_r_done;
  logic      l_b_done;
  logic      slots_none_free;
  slot_idx_t atop_slot;
  meta_t     fifo_r_meta;
  meta_t     fifo_b_meta;
  meta_t     slot_r_meta;
  meta_t     slot_b_meta;

  // Any non-zero atop[5:4] marks an atomic
  assign is_atop_aw = l_aw_valid_i && (l_aw_atop_i[AtopWidth-1 -: 2] != AtopNone);
  assign atop_has_r = l_aw_atop_i[AtopRRespBit];
  assign is_atop_r  = n_r_valid_i && (n_r_id_i < MaxAtomicTxns);
  assign is_atop_b  = n_b_valid_i && (n_b_id_i < MaxAtomicTxns);

  // AR path
  assign n_ar_valid_o = l_ar_valid_i && !ar_full;
  assign l_ar_ready_o = n_ar_ready_i && !ar_full;
  assign n_ar_id_o    = id_out_t'(NoAtopOutId);
  assign n_ar_addr_o  = l_ar_addr_i;

  // Atomic writes wait for a free slot and other writes for FIFO room
  assign aw_blocked   = is_atop_aw ? slots_none_free : aw_full;
  assign n_aw_valid_o = l_aw_valid_i && !aw_blocked;
  assign l_aw_ready_o = n_aw_ready_i && !aw_blocked;
  assign n_aw_id_o    = is_atop_aw ? id_out_t'(atop_slot) : id_out_t'(NoAtopOutId);
  assign n_aw_addr_o  = l_aw_addr_i;
  assign n_aw_atop_o  = l_aw_atop_i;
  assign aw_hs        = n_aw_valid_o && n_aw_ready_i;

  // Responses pass straight through
  assign l_r_valid_o = n_r_valid_i;
  assign n_r_ready_o = l_r_ready_i;
  assign l_r_data_o  = n_r_data_i;
  assign l_r_last_o  = n_r_last_i;
  assign l_b_valid_o = n_b_valid_i;
  assign n_b_ready_o = l_b_ready_i;

  // R records leave on the last beat only
  assign l_r_done = l_r_valid_o && l_r_ready_i && l_r_last_o;
  assign l_b_done = l_b_valid_o && l_b_ready_i;

  assign r_meta_o = is_atop_r ? slot_r_meta : fifo_r_meta;
  assign b_meta_o = is_atop_b ? slot_b_meta : fifo_b_meta;
  assign l_r_id_o = r_meta_o[InIdWidth-1:0];
  assign l_b_id_o = b_meta_o[InIdWidth-1:0];

  meta_fifo u_ar_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (n_ar_valid_o && n_ar_ready_i),
    .meta_i  (ar_meta_i),
    .pop_i   (l_r_done && !is_atop_r),
    .meta_o  (fifo_r_meta),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

  meta_fifo u_aw_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (aw_hs && !is_atop_aw),
    .meta_i  (aw_meta_i),
    .pop_i   (l_b_done && !is_atop_b),
    .meta_o  (fifo_b_meta),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  atop_slots u_slots (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .alloc_i     (aw_hs && is_atop_aw),
    .alloc_r_i   (aw_hs && is_atop_aw && atop_has_r),
    .aw_meta_i   (aw_meta_i),
    .ar_meta_i   (ar_meta_i),
    .hold_i      (is_atop_aw && n_aw_valid_o && !n_aw_ready_i),
    .slot_o      (atop_slot),
    .none_free_o (slots_none_free),
    .b_free_i    (l_b_done && is_atop_b),
    .b_slot_i    (slot_idx_t'(n_b_id_i)),
    .r_free_i    (l_r_done && is_atop_r),
    .r_slot_i    (slot_idx_t'(n_r_id_i)),
    .b_meta_o    (slot_b_meta),
    .r_meta_o    (slot_r_meta)
  );

  // Network must only answer requests that were issued
  a_r_has_record: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (n_r_valid_i && !is_atop_r) |-> !ar_empty);
  a_b_has_record: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (n_b_valid_i && !is_atop_b) |-> !aw_empty);

endmodule

// ==== meta_buffer/meta_fifo.sv ====
/*
 * Meta FIFO
 * In-order store of meta records for ordinary requests
 */
`timescale 1ns/10ps

module meta_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  ni_types_pkg::meta_t meta_i,
  input  logic                pop_i,
  output ni_types_pkg::meta_t meta_o,
  output logic                full_o,
  output logic                empty_o
);

  import ni_cfg_pkg::*;
  import ni_types_pkg::*;

  meta_t                   mem_q [MaxTxns];
  logic [FifoPtrWidth-1:0] wr_ptr_q;
  logic [FifoPtrWidth-1:0] rd_ptr_q;
  logic [FifoPtrWidth:0]   count_q;

  assign full_o  = (count_q == (FifoPtrWidth+1)'(MaxTxns));
  assign empty_o = (count_q == '0);
  assign meta_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == FifoPtrWidth'(MaxTxns-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == FifoPtrWidth'(MaxTxns-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= meta_i;
    end
  end

  // Caller gates requests and responses on the flags
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

// ==== test/tb_clock.sv ====
/*
 * Testbench clock and reset
 * Free-running clock with an active-low reset held for the first cycles
 */
`timescale 1ns/10ps

module tb_clock #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== test/tb_ni_top.sv ====
/*
 * NI top testbench
 * Directed tests of ID remap, meta return, buffer-full gating and
 * atomic slot handling, with a simple network-side responder
 */
`timescale 1ns/10ps

module tb_ni_top;

  import ni_cfg_pkg::*;
  import ni_types_pkg::*;

  // Outputs are sampled this long after the falling edge
  localparam int unsigned SettleNs = 10;
  // All tests together take about 60 cycles
  localparam int unsigned TimeoutCycles = 2000;
  localparam atop_t   AtopLoad   = 6'b10_0000;
  localparam atop_t   AtopStore  = 6'b01_0000;
  localparam atop_t   AtopNoneOp = 6'b00_0000;
  localparam id_out_t OrdId      = 3'd7;
  localparam id_out_t Slot0Id    = 3'd0;
  localparam id_out_t Slot1Id    = 3'd1;

  logic    clk;
  logic    rst_n;
  logic    l_ar_valid_i;
  logic    l_ar_ready_o;
  id_in_t  l_ar_id_i;
  addr_t   l_ar_addr_i;
  logic    l_aw_valid_i;
  logic    l_aw_ready_o;
  id_in_t  l_aw_id_i;
  addr_t   l_aw_addr_i;
  atop_t   l_aw_atop_i;
  logic    l_r_valid_o;
  logic    l_r_ready_i;
  id_in_t  l_r_id_o;
  data_t   l_r_data_o;
  logic    l_r_last_o;
  logic    l_b_valid_o;
  logic    l_b_ready_i;
  id_in_t  l_b_id_o;
  logic    n_ar_valid_o;
  logic    n_ar_ready_i;
  id_out_t n_ar_id_o;
  addr_t   n_ar_addr_o;
  logic    n_aw_valid_o;
  logic    n_aw_ready_i;
  id_out_t n_aw_id_o;
  addr_t   n_aw_addr_o;
  atop_t   n_aw_atop_o;
  logic    n_r_valid_i;
  logic    n_r_ready_o;
  id_out_t n_r_id_i;
  data_t   n_r_data_i;
  logic    n_r_last_i;
  logic    n_b_valid_i;
  logic    n_b_ready_o;
  id_out_t n_b_id_i;
  meta_t   ar_meta_i;
  meta_t   aw_meta_i;
  meta_t   r_meta_o;
  meta_t   b_meta_o;

  int unsigned errors = 0;
  int unsigned tests = 0;
  int unsigned cycles = 0;
  // Responder view of IDs still owed a response
  id_out_t     ar_issued_q[$];
  id_out_t     aw_issued_q[$];

  tb_clock #(.PeriodNs(40), .ResetCycles(4)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

  ni_top dut0 (.clk_i(clk), .rst_n_i(rst_n), .*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %t: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic start_ar(input id_in_t id, output meta_t meta);
    meta = {src_t'($urandom), id};
    l_ar_valid_i = 1'b1;
    l_ar_id_i    = id;
    l_ar_addr_i  = $urandom;
    ar_meta_i    = meta;
  endtask

  task automatic wait_ar_accept();
    #(SettleNs);
    while (!l_ar_ready_o) begin
      @(negedge clk);
      #(SettleNs);
    end
    if (n_ar_valid_o !== 1'b1) report_mismatch("n_ar_valid_o", n_ar_valid_o, 1);
    if (n_ar_id_o !== OrdId) report_mismatch("n_ar_id_o", n_ar_id_o, OrdId);
    if (n_ar_addr_o !== l_ar_addr_i) report_mismatch("n_ar_addr_o", n_ar_addr_o, l_ar_addr_i);
    ar_issued_q.push_back(n_ar_id_o);
    @(negedge clk);
    l_ar_valid_i = 1'b0;
  endtask

  // r_meta is stored from ar_meta_i for atomics that return R data
  task automatic start_aw(input id_in_t id, input atop_t atop, output meta_t meta,
                          output meta_t r_meta);
    meta   = {src_t'($urandom), id};
    r_meta = {src_t'($urandom), id};
    l_aw_valid_i = 1'b1;
    l_aw_id_i    = id;
    l_aw_addr_i  = $urandom;
    l_aw_atop_i  = atop;
    aw_meta_i    = meta;
    ar_meta_i    = r_meta;
  endtask

  task automatic wait_aw_accept(input id_out_t exp_id);
    #(SettleNs);
    while (!l_aw_ready_o) begin
      @(negedge clk);
      #(SettleNs);
    end
    if (n_aw_valid_o !== 1'b1) report_mismatch("n_aw_valid_o", n_aw_valid_o, 1);
    if (n_aw_id_o !== exp_id) report_mismatch("n_aw_id_o", n_aw_id_o, exp_id);
    if (n_aw_addr_o !== l_aw_addr_i) report_mismatch("n_aw_addr_o", n_aw_addr_o, l_aw_addr_i);
    if (n_aw_atop_o !== l_aw_atop_i) report_mismatch("n_aw_atop_o", n_aw_atop_o, l_aw_atop_i);
    aw_issued_q.push_back(n_aw_id_o);
    if (l_aw_atop_i[AtopRRespBit]) begin
      ar_issued_q.push_back(n_aw_id_o);
    end
    @(negedge clk);
    l_aw_valid_i = 1'b0;
  endtask

  task automatic retire_id(input logic is_r, input id_out_t id);
    int idx;
    idx = -1;
    if (is_r) begin
      for (int i = 0; i < ar_issued_q.size(); i++) begin
        if (idx < 0 && ar_issued_q[i] == id) idx = i;
      end
      if (idx >= 0) ar_issued_q.delete(idx);
    end else begin
      for (int i = 0; i < aw_issued_q.size(); i++) begin
        if (idx < 0 && aw_issued_q[i] == id) idx = i;
      end
      if (idx >= 0) aw_issued_q.delete(idx);
    end
    if (idx < 0) begin
      $display("Response with ID %0d was sent but no request used that ID", id);
      errors++;
    end
  endtask

  task automatic send_r(input id_out_t id, input int beats, input meta_t exp_meta);
    data_t data;
    for (int b = 0; b < beats; b++) begin
      data        = $urandom;
      n_r_valid_i = 1'b1;
      n_r_id_i    = id;
      n_r_data_i  = data;
      n_r_last_i  = (b == beats - 1);
      #(SettleNs);
      if (l_r_valid_o !== 1'b1) report_mismatch("l_r_valid_o", l_r_valid_o, 1);
      if (n_r_ready_o !== 1'b1) report_mismatch("n_r_ready_o", n_r_ready_o, 1);
      if (l_r_id_o !== exp_meta[InIdWidth-1:0]) begin
        report_mismatch("l_r_id_o", l_r_id_o, exp_meta[InIdWidth-1:0]);
      end
      if (r_meta_o !== exp_meta) report_mismatch("r_meta_o", r_meta_o, exp_meta);
      if (l_r_data_o !== data) report_mismatch("l_r_data_o", l_r_data_o, data);
      if (l_r_last_o !== n_r_last_i) report_mismatch("l_r_last_o", l_r_last_o, n_r_last_i);
      @(negedge clk);
    end
    n_r_valid_i = 1'b0;
    n_r_last_i  = 1'b0;
    retire_id(1'b1, id);
  endtask

  // Local ready stays low for the stall cycles while the record holds still
  task automatic send_b(input id_out_t id, input meta_t exp_meta, input int stall);
    n_b_valid_i = 1'b1;
    n_b_id_i    = id;
    for (int c = 0; c <= stall; c++) begin
      l_b_ready_i = (c == stall);
      #(SettleNs);
      if (l_b_valid_o !== 1'b1) report_mismatch("l_b_valid_o", l_b_valid_o, 1);
      if (n_b_ready_o !== l_b_ready_i) report_mismatch("n_b_ready_o", n_b_ready_o, l_b_ready_i);
      if (l_b_id_o !== exp_meta[InIdWidth-1:0]) begin
        report_mismatch("l_b_id_o", l_b_id_o, exp_meta[InIdWidth-1:0]);
      end
      if (b_meta_o !== exp_meta) report_mismatch("b_meta_o", b_meta_o, exp_meta);
      @(negedge clk);
    end
    n_b_valid_i = 1'b0;
    retire_id(1'b0, id);
  endtask

  task automatic ordinary_read_remap();
    meta_t m;
    tests++;
    #(SettleNs);
    if (n_ar_valid_o !== 1'b0) report_mismatch("n_ar_valid_o", n_ar_valid_o, 0);
    if (l_r_valid_o !== 1'b0) report_mismatch("l_r_valid_o", l_r_valid_o, 0);
    @(negedge clk);
    start_ar(4'h5, m);
    wait_ar_accept();
    send_r(OrdId, 3, m);
  endtask

  task automatic ordinary_writes_in_order();
    meta_t m [3];
    meta_t unused_r;
    tests++;
    for (int i = 0; i < 3; i++) begin
      start_aw(id_in_t'(i + 1), AtopNoneOp, m[i], unused_r);
      wait_aw_accept(OrdId);
    end
    for (int i = 0; i < 3; i++) begin
      send_b(OrdId, m[i], i);
    end
  endtask

  task automatic atomic_rsp_out_of_order();
    meta_t b0;
    meta_t r0;
    meta_t b1;
    meta_t unused_r;
    tests++;
    start_aw(4'hA, AtopLoad, b0, r0);
    wait_aw_accept(Slot0Id);
    start_aw(4'hB, AtopStore, b1, unused_r);
    wait_aw_accept(Slot1Id);
    send_b(Slot1Id, b1, 0);
    send_r(Slot0Id, 2, r0);
    send_b(Slot0Id, b0, 1);
  endtask

  task automatic ar_blocked_when_full();
    meta_t m [MaxTxns];
    meta_t extra;
    tests++;
    for (int i = 0; i < MaxTxns; i++) begin
      start_ar(id_in_t'(i), m[i]);
      wait_ar_accept();
    end
    start_ar(4'hC, extra);
    repeat (2) begin
      #(SettleNs);
      if (l_ar_ready_o !== 1'b0) report_mismatch("l_ar_ready_o", l_ar_ready_o, 0);
      if (n_ar_valid_o !== 1'b0) report_mismatch("n_ar_valid_o", n_ar_valid_o, 0);
      @(negedge clk);
    end
    send_r(OrdId, 1, m[0]);
    wait_ar_accept();
    for (int i = 1; i < MaxTxns; i++) begin
      send_r(OrdId, 2, m[i]);
    end
    send_r(OrdId, 1, extra);
  endtask

  task automatic atomic_blocked_without_slot();
    meta_t s0;
    meta_t s1;
    meta_t ord;
    meta_t late;
    meta_t unused_r;
    tests++;
    start_aw(4'h1, AtopStore, s0, unused_r);
    wait_aw_accept(Slot0Id);
    start_aw(4'h2, AtopStore, s1, unused_r);
    wait_aw_accept(Slot1Id);
    start_aw(4'h3, AtopStore, late, unused_r);
    #(SettleNs);
    if (l_aw_ready_o !== 1'b0) report_mismatch("l_aw_ready_o", l_aw_ready_o, 0);
    if (n_aw_valid_o !== 1'b0) report_mismatch("n_aw_valid_o", n_aw_valid_o, 0);
    @(negedge clk);
    // Withdraw the atomic so an ordinary write can use the channel
    l_aw_valid_i = 1'b0;
    start_aw(4'h4, AtopNoneOp, ord, unused_r);
    wait_aw_accept(OrdId);
    l_aw_valid_i = 1'b1;
    l_aw_id_i    = 4'h3;
    l_aw_atop_i  = AtopStore;
    aw_meta_i    = late;
    #(SettleNs);
    if (n_aw_valid_o !== 1'b0) report_mismatch("n_aw_valid_o", n_aw_valid_o, 0);
    @(negedge clk);
    send_b(Slot0Id, s0, 0);
    wait_aw_accept(Slot0Id);
    send_b(Slot1Id, s1, 0);
    send_b(OrdId, ord, 0);
    send_b(Slot0Id, late, 0);
  endtask

  task automatic atomic_id_held_on_stall();
    meta_t s0;
    meta_t held;
    meta_t unused_r;
    tests++;
    start_aw(4'h6, AtopStore, s0, unused_r);
    wait_aw_accept(Slot0Id);
    n_aw_ready_i = 1'b0;
    start_aw(4'h7, AtopStore, held, unused_r);
    #(SettleNs);
    if (n_aw_valid_o !== 1'b1) report_mismatch("n_aw_valid_o", n_aw_valid_o, 1);
    if (n_aw_id_o !== Slot1Id) report_mismatch("n_aw_id_o", n_aw_id_o, Slot1Id);
    @(negedge clk);
    // Slot 0 frees up mid-stall but the offered ID stays on slot 1
    send_b(Slot0Id, s0, 1);
    #(SettleNs);
    if (n_aw_id_o !== Slot1Id) report_mismatch("n_aw_id_o", n_aw_id_o, Slot1Id);
    @(negedge clk);
    n_aw_ready_i = 1'b1;
    wait_aw_accept(Slot1Id);
    send_b(Slot1Id, held, 0);
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(32'h3543_cafa));
    l_ar_valid_i = 1'b0;
    l_ar_id_i    = '0;
    l_ar_addr_i  = '0;
    l_aw_valid_i = 1'b0;
    l_aw_id_i    = '0;
    l_aw_addr_i  = '0;
    l_aw_atop_i  = '0;
    l_r_ready_i  = 1'b1;
    l_b_ready_i  = 1'b1;
    n_ar_ready_i = 1'b1;
    n_aw_ready_i = 1'b1;
    n_r_valid_i  = 1'b0;
    n_r_id_i     = '0;
    n_r_data_i   = '0;
    n_r_last_i   = 1'b0;
    n_b_valid_i  = 1'b0;
    n_b_id_i     = '0;
    ar_meta_i    = '0;
    aw_meta_i    = '0;
    @(posedge rst_n);
    @(negedge clk);
    ordinary_read_remap();
    ordinary_writes_in_order();
    atomic_rsp_out_of_order();
    ar_blocked_when_full();
    atomic_blocked_without_slot();
    atomic_id_held_on_stall();
    if (ar_issued_q.size() != 0 || aw_issued_q.size() != 0) begin
      $display("Requests were left without a response at the end of the run");
      errors++;
    end
    repeat (2) @(negedge clk);
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== verilog/ni_top.sv ====
/*
 * NI top
 * Local and network AXI-style ports around the meta buffer
 */
`timescale 1ns/10ps

module ni_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  l_ar_valid_i,
  output logic                  l_ar_ready_o,
  input  ni_types_pkg::id_in_t  l_ar_id_i,
  input  ni_types_pkg::addr_t   l_ar_addr_i,
  input  logic                  l_aw_valid_i,
  output logic                  l_aw_ready_o,
  input  ni_types_pkg::id_in_t  l_aw_id_i,
  input  ni_types_pkg::addr_t   l_aw_addr_i,
  input  ni_types_pkg::atop_t   l_aw_atop_i,
  output logic                  l_r_valid_o,
  input  logic                  l_r_ready_i,
  output ni_types_pkg::id_in_t  l_r_id_o,
  output ni_types_pkg::data_t   l_r_data_o,
  output logic                  l_r_last_o,
  output logic                  l_b_valid_o,
  input  logic                  l_b_ready_i,
  output ni_types_pkg::id_in_t  l_b_id_o,
  output logic                  n_ar_valid_o,
  input  logic                  n_ar_ready_i,
  output ni_types_pkg::id_out_t n_ar_id_o,
  output ni_types_pkg::addr_t   n_ar_addr_o,
  output logic                  n_aw_valid_o,
  input  logic                  n_aw_ready_i,
  output ni_types_pkg::id_out_t n_aw_id_o,
  output ni_types_pkg::addr_t   n_aw_addr_o,
  output ni_types_pkg::atop_t   n_aw_atop_o,
  input  logic                  n_r_valid_i,
  output logic                  n_r_ready_o,
  input  ni_types_pkg::id_out_t n_r_id_i,
  input  ni_types_pkg::data_t   n_r_data_i,
  input  logic                  n_r_last_i,
  input  logic                  n_b_valid_i,
  output logic                  n_b_ready_o,
  input  ni_types_pkg::id_out_t n_b_id_i,
  input  ni_types_pkg::meta_t   ar_meta_i,
  input  ni_types_pkg::meta_t   aw_meta_i,
  output ni_types_pkg::meta_t   r_meta_o,
  output ni_types_pkg::meta_t   b_meta_o
);

  import ni_cfg_pkg::*;
  import ni_types_pkg::*;

  // Port names match one to one
  meta_buffer u_meta_buffer (.*);

endmodule
